// File: compile.f
+incdir+hw
hw/corePkg.sv
hw/coreIfs.sv
hw/regFile.sv
hw/mulPipe.sv
hw/decodeStage.sv
hw/execStage.sv
hw/resultStage.sv
hw/coreTop.sv
testbench/coreChecker.sv
testbench/tbCore.sv

// File: hw/coreIfs.sv
`timescale 1ns/1ps

interface issueIf;
    logic              valid;
    corePkg::sqN_t     sqN;
    corePkg::opcode_t  op;
    corePkg::regIdx_t  rd;
    corePkg::word_t    opA;
    corePkg::word_t    opB;

    modport source (output valid, sqN, op, rd, opA, opB);
    modport receiver (input valid, sqN, op, rd, opA, opB);
endinterface

interface wbIf;
    logic              valid;
    corePkg::sqN_t     sqN;
    corePkg::regIdx_t  rd;
    corePkg::word_t    result;

    modport source (output valid, sqN, rd, result);
    modport receiver (input valid, sqN, rd, result);
endinterface

interface commitIf;
    logic              valid;
    corePkg::sqN_t     sqN;
    corePkg::regIdx_t  rd;
    corePkg::word_t    result;

    modport source (output valid, sqN, rd, result);
    modport receiver (input valid, sqN, rd, result);
endinterface

// File: hw/corePkg.sv
package corePkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [3:0]  regIdx_t;
    typedef logic [3:0]  opcode_t;

    // wraps modulo 16, twice the reorder buffer depth, so head and tail stay apart.
    typedef logic [3:0]  sqN_t;

    localparam opcode_t OP_ADD  = 4'd0;
    localparam opcode_t OP_SUB  = 4'd1;
    localparam opcode_t OP_AND  = 4'd2;
    localparam opcode_t OP_OR   = 4'd3;
    localparam opcode_t OP_XOR  = 4'd4;

    // shift amount comes from operand B bits 4..0.
    localparam opcode_t OP_SLL  = 4'd5;

    // operand B is the sign-extended immediate.
    localparam opcode_t OP_ADDI = 4'd6;

    // operand B is the immediate in the upper half and is also the result.
    localparam opcode_t OP_LUI  = 4'd7;

    // only the low 32 bits of the product are kept.
    localparam opcode_t OP_MUL  = 4'd8;

endpackage

// File: hw/coreTop.sv
`timescale 1ns/1ps

module coreTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              instrValid,
    input  corePkg::instr_t   instr,
    output logic              instrCredit,
    output logic              comValid,
    output corePkg::sqN_t     comSqN,
    output corePkg::regIdx_t  comRd,
    output corePkg::word_t    comResult
);

    corePkg::regIdx_t rdAddrA;
    corePkg::regIdx_t rdAddrB;
    corePkg::word_t   rdDataA;
    corePkg::word_t   rdDataB;
    logic             robCredit;

    issueIf  issBus ();
    wbIf     aluWb ();
    wbIf     mulWb ();
    commitIf comBus ();

    decodeStage i_decodeStage (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrCredit (instrCredit),
        .rdAddrA     (rdAddrA),
        .rdAddrB     (rdAddrB),
        .rdDataA     (rdDataA),
        .rdDataB     (rdDataB),
        .robCredit   (robCredit),
        .com         (comBus.receiver),
        .iss         (issBus.source)
    );

    execStage i_execStage (
        .clk   (clk),
        .rst   (rst),
        .iss   (issBus.receiver),
        .aluWb (aluWb.source),
        .mulWb (mulWb.source)
    );

    resultStage i_resultStage (
        .clk       (clk),
        .rst       (rst),
        .aluWb     (aluWb.receiver),
        .mulWb     (mulWb.receiver),
        .com       (comBus.source),
        .robCredit (robCredit)
    );

    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .com     (comBus.receiver)
    );

    assign comValid  = comBus.valid;
    assign comSqN    = comBus.sqN;
    assign comRd     = comBus.rd;
    assign comResult = comBus.result;

endmodule

// File: hw/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// entries in the instruction buffer.
// The source starts with this many credits after reset.
`define IBUF_DEPTH 4

// entries in the reorder buffer.
// The decode stage starts with this many credits.
// Sequence numbers wrap at twice this value.
`define ROB_DEPTH 8

// register stages in the multiplier.
// A multiply reaches its writeback port this many cycles after issue.
`define MUL_LAT 3

`endif

// File: hw/decodeStage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module decodeStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              instrValid,
    input  corePkg::instr_t   instr,
    output logic              instrCredit,
    output corePkg::regIdx_t  rdAddrA,
    output corePkg::regIdx_t  rdAddrB,
    input  corePkg::word_t    rdDataA,
    input  corePkg::word_t    rdDataB,
    input  logic              robCredit,
    commitIf.receiver         com,
    issueIf.source            iss
);

    localparam int BufAw = $clog2(`IBUF_DEPTH);
    localparam int BufCw = $clog2(`IBUF_DEPTH + 1);
    localparam int RobCw = $clog2(`ROB_DEPTH + 1);

    corePkg::instr_t   bufMem [`IBUF_DEPTH];
    logic [BufAw-1:0]  wrPtr;
    logic [BufAw-1:0]  rdPtr;
    logic [BufCw-1:0]  bufCnt;
    logic              bufEmpty;
    logic              bufFull;

    logic [RobCw-1:0]  robCnt;
    corePkg::sqN_t     nextSqN;

    // per register: a write is in flight, and the sqN of its youngest writer.
    logic [15:0]       pending;
    corePkg::sqN_t     youngest [16];

    corePkg::instr_t   head;
    corePkg::opcode_t  op;
    corePkg::regIdx_t  rd;
    logic [15:0]       imm;
    logic              useA;
    logic              useB;
    logic              hazard;
    logic              issue;
    corePkg::word_t    opB;

    assign bufEmpty = (bufCnt == '0);
    assign bufFull  = (bufCnt == BufCw'(`IBUF_DEPTH));

    assign head    = bufMem[rdPtr];
    assign op      = head[31:28];
    assign rd      = head[27:24];
    assign rdAddrA = head[23:20];
    assign rdAddrB = head[19:16];
    assign imm     = head[15:0];

    // LUI reads no register and ADDI reads only rs1.
    assign useA   = (op != corePkg::OP_LUI);
    assign useB   = (op != corePkg::OP_LUI) && (op != corePkg::OP_ADDI);
    assign hazard = (useA && pending[rdAddrA]) || (useB && pending[rdAddrB]);
    assign issue  = !bufEmpty && (robCnt != '0) && !hazard;

    always_comb begin
        case (op)
            corePkg::OP_ADDI: opB = {{16{imm[15]}}, imm};
            corePkg::OP_LUI:  opB = {imm, 16'h0000};
            default:          opB = rdDataB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            bufMem[wrPtr] <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            bufCnt <= '0;
        end else begin
            if (instrValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (issue) begin
                rdPtr <= rdPtr + 1'b1;
            end
            bufCnt <= bufCnt + BufCw'(instrValid) - BufCw'(issue);
        end
    end

    // an older writer committing must not release a register that a younger one still owns.
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (com.valid && pending[com.rd] && youngest[com.rd] == com.sqN) begin
                pending[com.rd] <= 1'b0;
            end
            if (issue && rd != '0) begin
                pending[rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            youngest[rd] <= nextSqN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iss.valid   <= 1'b0;
            instrCredit <= 1'b0;
            nextSqN     <= '0;
            robCnt      <= RobCw'(`ROB_DEPTH);
        end else begin
            iss.valid   <= issue;
            instrCredit <= issue;
            if (issue) begin
                nextSqN <= nextSqN + 1'b1;
            end
            robCnt <= robCnt + RobCw'(robCredit) - RobCw'(issue);
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            iss.sqN <= nextSqN;
            iss.op  <= op;
            iss.rd  <= rd;
            iss.opA <= rdDataA;
            iss.opB <= opB;
        end
    end

    bufNoOverflow: assert property (@(posedge clk) disable iff (rst)
        instrValid |-> !bufFull)
        else $error("instruction pushed into a full buffer");

    robCreditBound: assert property (@(posedge clk) disable iff (rst)
        robCnt <= RobCw'(`ROB_DEPTH))
        else $error("reorder buffer credits exceed its depth");

endmodule

// File: hw/execStage.sv
`timescale 1ns/1ps

module execStage (
    input  logic      clk,
    input  logic      rst,
    issueIf.receiver  iss,
    wbIf.source       aluWb,
    wbIf.source       mulWb
);

    corePkg::word_t aluOut;
    logic           isMul;

    assign isMul = (iss.op == corePkg::OP_MUL);

    // unknown opcodes fall back to an add.
    always_comb begin
        case (iss.op)
            corePkg::OP_SUB: aluOut = iss.opA - iss.opB;
            corePkg::OP_AND: aluOut = iss.opA & iss.opB;
            corePkg::OP_OR:  aluOut = iss.opA | iss.opB;
            corePkg::OP_XOR: aluOut = iss.opA ^ iss.opB;
            corePkg::OP_SLL: aluOut = iss.opA << iss.opB[4:0];
            corePkg::OP_LUI: aluOut = iss.opB;
            default:         aluOut = iss.opA + iss.opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluWb.valid <= 1'b0;
        end else begin
            aluWb.valid <= iss.valid && !isMul;
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid && !isMul) begin
            aluWb.sqN    <= iss.sqN;
            aluWb.rd     <= iss.rd;
            aluWb.result <= aluOut;
        end
    end

    mulPipe i_mulPipe (
        .clk       (clk),
        .rst       (rst),
        .inValid   (iss.valid && isMul),
        .inSqN     (iss.sqN),
        .inRd      (iss.rd),
        .inA       (iss.opA),
        .inB       (iss.opB),
        .outValid  (mulWb.valid),
        .outSqN    (mulWb.sqN),
        .outRd     (mulWb.rd),
        .outResult (mulWb.result)
    );

endmodule

// File: hw/mulPipe.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module mulPipe (
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  corePkg::sqN_t     inSqN,
    input  corePkg::regIdx_t  inRd,
    input  corePkg::word_t    inA,
    input  corePkg::word_t    inB,
    output logic              outValid,
    output corePkg::sqN_t     outSqN,
    output corePkg::regIdx_t  outRd,
    output corePkg::word_t    outResult
);

    logic [`MUL_LAT-1:0] vld;
    corePkg::sqN_t       sqNPipe [`MUL_LAT];
    corePkg::regIdx_t    rdPipe [`MUL_LAT];
    corePkg::word_t      prodPipe [`MUL_LAT];
    corePkg::word_t      product;

    // the later stages leave room for synthesis to retime the multiplier.
    assign product = inA * inB;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld[0] <= inValid;
            for (int s = 1; s < `MUL_LAT; s++) begin
                vld[s] <= vld[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        sqNPipe[0]  <= inSqN;
        rdPipe[0]   <= inRd;
        prodPipe[0] <= product;
        for (int s = 1; s < `MUL_LAT; s++) begin
            sqNPipe[s]  <= sqNPipe[s-1];
            rdPipe[s]   <= rdPipe[s-1];
            prodPipe[s] <= prodPipe[s-1];
        end
    end

    assign outValid  = vld[`MUL_LAT-1];
    assign outSqN    = sqNPipe[`MUL_LAT-1];
    assign outRd     = rdPipe[`MUL_LAT-1];
    assign outResult = prodPipe[`MUL_LAT-1];

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  corePkg::regIdx_t  rdAddrA,
    input  corePkg::regIdx_t  rdAddrB,
    output corePkg::word_t    rdDataA,
    output corePkg::word_t    rdDataB,
    commitIf.receiver         com
);

    corePkg::word_t regs [16];

    // only committed results reach the architectural state.
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (com.valid && com.rd != '0) begin
            regs[com.rd] <= com.result;
        end
    end

    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: hw/resultStage.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module resultStage (
    input  logic     clk,
    input  logic     rst,
    wbIf.receiver    aluWb,
    wbIf.receiver    mulWb,
    commitIf.source  com,
    output logic     robCredit
);

    localparam int RobAw = $clog2(`ROB_DEPTH);

    logic [`ROB_DEPTH-1:0] done;
    corePkg::regIdx_t      slotRd [`ROB_DEPTH];
    corePkg::word_t        slotResult [`ROB_DEPTH];
    corePkg::sqN_t         headSqN;
    logic [RobAw-1:0]      headIdx;
    logic [RobAw-1:0]      aluIdx;
    logic [RobAw-1:0]      mulIdx;
    logic                  commit;

    assign headIdx = headSqN[RobAw-1:0];
    assign aluIdx  = aluWb.sqN[RobAw-1:0];
    assign mulIdx  = mulWb.sqN[RobAw-1:0];

    // the head commits as soon as its result is in.
    assign commit = done[headIdx];

    assign com.valid  = commit;
    assign com.sqN    = headSqN;
    assign com.rd     = slotRd[headIdx];
    assign com.result = slotResult[headIdx];
    assign robCredit  = commit;

    always_ff @(posedge clk) begin
        if (rst) begin
            done    <= '0;
            headSqN <= '0;
        end else begin
            if (commit) begin
                done[headIdx] <= 1'b0;
                headSqN       <= headSqN + 1'b1;
            end
            if (aluWb.valid) begin
                done[aluIdx] <= 1'b1;
            end
            if (mulWb.valid) begin
                done[mulIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aluWb.valid) begin
            slotRd[aluIdx]     <= aluWb.rd;
            slotResult[aluIdx] <= aluWb.result;
        end
        if (mulWb.valid) begin
            slotRd[mulIdx]     <= mulWb.rd;
            slotResult[mulIdx] <= mulWb.result;
        end
    end

    aluSlotFree: assert property (@(posedge clk) disable iff (rst)
        aluWb.valid |-> !done[aluIdx])
        else $error("ALU writeback hit a slot that is already done");

    mulSlotFree: assert property (@(posedge clk) disable iff (rst)
        mulWb.valid |-> !done[mulIdx])
        else $error("multiplier writeback hit a slot that is already done");

    wbDistinct: assert property (@(posedge clk) disable iff (rst)
        (aluWb.valid && mulWb.valid) |-> (aluWb.sqN != mulWb.sqN))
        else $error("both writeback ports carry the same sqN");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tbCore -f compile.f -o simCore
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simCore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: testbench/coreChecker.sv
`timescale 1ns/1ps

module coreChecker (
    input logic              clk,
    input logic              rst,
    input logic              comValid,
    input corePkg::sqN_t     comSqN,
    input corePkg::regIdx_t  comRd,
    input corePkg::word_t    comResult
);

    corePkg::sqN_t     expSqN [$];
    corePkg::regIdx_t  expRd [$];
    corePkg::word_t    expResult [$];
    string             expTest [$];

    int mismatches = 0;
    int protocolErrors = 0;
    int commits = 0;

    function automatic void addExpected(input corePkg::sqN_t sqN, input corePkg::regIdx_t rd,
                                        input corePkg::word_t result, input string testName);
        expSqN.push_back(sqN);
        expRd.push_back(rd);
        expResult.push_back(result);
        expTest.push_back(testName);
    endfunction

    function automatic int pendingCount();
        return expSqN.size();
    endfunction

    // the commit port is sampled at the rising edge, before the reorder buffer head moves.
    always @(posedge clk) begin : checkCommit
        corePkg::sqN_t     wantSqN;
        corePkg::regIdx_t  wantRd;
        corePkg::word_t    wantResult;
        string             name;
        if (!rst && comValid) begin
            commits++;
            if (expSqN.size() == 0) begin
                $display("ERROR: commit of sqN %0d arrived with no instruction outstanding",
                         comSqN);
                protocolErrors++;
            end else begin
                wantSqN    = expSqN.pop_front();
                wantRd     = expRd.pop_front();
                wantResult = expResult.pop_front();
                name       = expTest.pop_front();
                if (comSqN !== wantSqN) begin
                    $display("mismatch in %s: sqN expected %0d, actual %0d",
                             name, wantSqN, comSqN);
                    mismatches++;
                end
                if (comRd !== wantRd) begin
                    $display("mismatch in %s: rd expected %0d, actual %0d",
                             name, wantRd, comRd);
                    mismatches++;
                end
                if (comResult !== wantResult) begin
                    $display("mismatch in %s: result expected %h, actual %h",
                             name, wantResult, comResult);
                    mismatches++;
                end
            end
        end
    end

endmodule

// File: testbench/tbCore.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module tbCore;

    localparam int CreditTimeout = 200;
    localparam int DrainTimeout  = 2000;
    localparam int RandomCount   = 300;

    logic              clk;
    logic              rst;
    logic              instrValid;
    corePkg::instr_t   instr;
    logic              instrCredit;
    logic              comValid;
    corePkg::sqN_t     comSqN;
    corePkg::regIdx_t  comRd;
    corePkg::word_t    comResult;

    corePkg::word_t    modelRegs [16];
    corePkg::sqN_t     nextSqN;
    string             testName;
    integer            seed;
    int                sentCount;
    int                creditPulses;
    int                tbErrors;
    bit                timedOut;

    coreTop i_coreTop (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrCredit (instrCredit),
        .comValid    (comValid),
        .comSqN      (comSqN),
        .comRd       (comRd),
        .comResult   (comResult)
    );

    coreChecker i_coreChecker (
        .clk       (clk),
        .rst       (rst),
        .comValid  (comValid),
        .comSqN    (comSqN),
        .comRd     (comRd),
        .comResult (comResult)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && instrCredit) begin
            creditPulses++;
            if (creditPulses > sentCount) begin
                $display("ERROR: instruction credit returned for an instruction never sent");
                tbErrors++;
            end
        end
    end

    // the reference model executes in program order against committed state only.
    function automatic corePkg::word_t refResult(input corePkg::instr_t word);
        corePkg::word_t a;
        corePkg::word_t b;
        a = (word[23:20] == 4'd0) ? 32'd0 : modelRegs[word[23:20]];
        b = (word[19:16] == 4'd0) ? 32'd0 : modelRegs[word[19:16]];
        case (word[31:28])
            corePkg::OP_SUB:  return a - b;
            corePkg::OP_AND:  return a & b;
            corePkg::OP_OR:   return a | b;
            corePkg::OP_XOR:  return a ^ b;
            corePkg::OP_SLL:  return a << b[4:0];
            corePkg::OP_ADDI: return a + {{16{word[15]}}, word[15:0]};
            corePkg::OP_LUI:  return {word[15:0], 16'h0000};
            corePkg::OP_MUL:  return a * b;
            default:          return a + b;
        endcase
    endfunction

    function automatic corePkg::instr_t mkInstr(input corePkg::opcode_t op, input int rd,
                                                input int rs1, input int rs2, input int imm);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), 16'(imm)};
    endfunction

    function automatic int creditsLeft();
        return `IBUF_DEPTH - sentCount + creditPulses;
    endfunction

    task automatic checkQuiet(input string phase);
        if (comValid !== 1'b0 || instrCredit !== 1'b0) begin
            $display("ERROR: comValid or instrCredit not low %s", phase);
            tbErrors++;
        end
    endtask

    // called at a falling edge; holds instrValid for exactly one cycle.
    task automatic sendInstr(input corePkg::instr_t word);
        int             waited;
        corePkg::word_t result;
        waited = 0;
        while (!timedOut && creditsLeft() == 0) begin
            @(negedge clk);
            waited++;
            if (waited > CreditTimeout) begin
                $display("ERROR: no instruction credit came back within %0d cycles in %s",
                         CreditTimeout, testName);
                timedOut = 1'b1;
            end
        end
        if (!timedOut) begin
            result = refResult(word);
            i_coreChecker.addExpected(nextSqN, word[27:24], result, testName);
            if (word[27:24] != 4'd0) begin
                modelRegs[word[27:24]] = result;
            end
            nextSqN    = nextSqN + 4'd1;
            instrValid = 1'b1;
            instr      = word;
            sentCount++;
            @(negedge clk);
            instrValid = 1'b0;
        end
    endtask

    task automatic aluProgram();
        testName = "aluProgram";
        sendInstr(mkInstr(corePkg::OP_ADDI, 1, 0, 0, 5));
        sendInstr(mkInstr(corePkg::OP_ADDI, 2, 1, 0, -3));
        sendInstr(mkInstr(corePkg::OP_SUB, 3, 1, 2, 0));
        sendInstr(mkInstr(corePkg::OP_AND, 4, 3, 1, 0));
        sendInstr(mkInstr(corePkg::OP_OR, 5, 4, 2, 0));
        sendInstr(mkInstr(corePkg::OP_XOR, 6, 5, 1, 0));
        sendInstr(mkInstr(corePkg::OP_SLL, 7, 6, 2, 0));
        sendInstr(mkInstr(corePkg::OP_LUI, 8, 0, 0, 16'h1234));
        sendInstr(mkInstr(corePkg::OP_ADD, 9, 8, 7, 0));
        // opcode 13 is undefined and must act as an add.
        sendInstr(mkInstr(4'd13, 10, 9, 1, 0));
        sendInstr(mkInstr(corePkg::OP_ADDI, 11, 0, 0, -1));
        sendInstr(mkInstr(corePkg::OP_SUB, 12, 0, 11, 0));
    endtask

    task automatic mulOrderProgram();
        testName = "mulOrderProgram";
        sendInstr(mkInstr(corePkg::OP_MUL, 13, 9, 11, 0));
        sendInstr(mkInstr(corePkg::OP_ADDI, 14, 0, 0, 7));
        sendInstr(mkInstr(corePkg::OP_XOR, 15, 1, 2, 0));
        sendInstr(mkInstr(corePkg::OP_ADD, 1, 14, 15, 0));
        sendInstr(mkInstr(corePkg::OP_MUL, 2, 13, 14, 0));
        sendInstr(mkInstr(corePkg::OP_ADD, 3, 2, 1, 0));
        sendInstr(mkInstr(corePkg::OP_MUL, 4, 8, 8, 0));
        sendInstr(mkInstr(corePkg::OP_MUL, 5, 3, 3, 0));
        sendInstr(mkInstr(corePkg::OP_SUB, 6, 14, 1, 0));
    endtask

    task automatic zeroRegProgram();
        testName = "zeroRegProgram";
        sendInstr(mkInstr(corePkg::OP_ADDI, 0, 1, 0, 100));
        sendInstr(mkInstr(corePkg::OP_ADD, 6, 0, 1, 0));
        sendInstr(mkInstr(corePkg::OP_MUL, 0, 1, 1, 0));
        sendInstr(mkInstr(corePkg::OP_OR, 7, 0, 0, 0));
        sendInstr(mkInstr(corePkg::OP_SUB, 8, 0, 1, 0));
        sendInstr(mkInstr(corePkg::OP_LUI, 0, 0, 0, 16'hbeef));
        sendInstr(mkInstr(corePkg::OP_ADD, 9, 0, 0, 0));
    endtask

    task automatic randomStream();
        corePkg::instr_t word;
        testName = "randomStream";
        for (int n = 0; n < RandomCount; n++) begin
            word = $random(seed);
            sendInstr(word);
        end
    endtask

    initial begin
        int waited;
        seed         = 82;
        sentCount    = 0;
        creditPulses = 0;
        tbErrors     = 0;
        timedOut     = 1'b0;
        nextSqN      = '0;
        rst          = 1'b1;
        instrValid   = 1'b0;
        instr        = '0;
        for (int r = 0; r < 16; r++) begin
            modelRegs[r] = '0;
        end

        // each falling edge follows a rising edge that saw reset.
        repeat (16) begin
            @(negedge clk);
            checkQuiet("during reset");
        end
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            checkQuiet("right after reset");
        end

        aluProgram();
        mulOrderProgram();
        zeroRegProgram();
        randomStream();

        waited = 0;
        while (!timedOut && i_coreChecker.pendingCount() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DrainTimeout) begin
                $display("ERROR: %0d instructions never committed",
                         i_coreChecker.pendingCount());
                timedOut = 1'b1;
            end
        end
        repeat (5) @(negedge clk);

        if (!timedOut && i_coreChecker.commits != sentCount) begin
            $display("ERROR: %0d instructions sent but %0d committed",
                     sentCount, i_coreChecker.commits);
            tbErrors++;
        end
        if (!timedOut && creditPulses != sentCount) begin
            $display("ERROR: %0d instructions sent but %0d credits returned",
                     sentCount, creditPulses);
            tbErrors++;
        end

        $display("errors: mismatches %0d, protocol %0d, testbench %0d, timeout %0d",
                 i_coreChecker.mismatches, i_coreChecker.protocolErrors, tbErrors, timedOut);
        if (timedOut || tbErrors != 0 || i_coreChecker.mismatches != 0
                || i_coreChecker.protocolErrors != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule
